//--- src/vga_pkg.sv
package vga_pkg;

    // 640x480 at 60 Hz, counts in pixel clocks and lines
    localparam int H_SYNC_LEN  = 96;
    localparam int H_BACK_LEN  = 48;
    localparam int H_ACTIVE    = 640;
    localparam int H_FRONT_LEN = 16;

    localparam int V_SYNC_LEN  = 2;
    localparam int V_BACK_LEN  = 33;
    localparam int V_ACTIVE    = 480;
    localparam int V_FRONT_LEN = 10;

    // One swatch of the 16x16 test grid
    localparam int SWATCH_W = 40;
    localparam int SWATCH_H = 30;

    localparam int COUNT_W = 10;

    typedef logic [7:0]         pix_index_t;
    // Red in [11:8], green in [7:4], blue in [3:0]
    typedef logic [11:0]        rgb444_t;
    typedef logic [COUNT_W-1:0] h_count_t;
    typedef logic [COUNT_W-1:0] v_count_t;

    // Sync is active low, blank active high
    typedef struct packed {
        logic hsync;
        logic vsync;
        logic hblank;
        logic vblank;
    } vga_flags_t;

    localparam vga_flags_t FLAGS_BLANK = '{
        hsync:  1'b0,
        vsync:  1'b0,
        hblank: 1'b1,
        vblank: 1'b1
    };

endpackage

//--- src/vga_timing.sv
`timescale 1ns/1ps

module vga_timing
    import vga_pkg::*;
#(
    parameter int H_SYNC_LEN  = vga_pkg::H_SYNC_LEN,
    parameter int H_BACK_LEN  = vga_pkg::H_BACK_LEN,
    parameter int H_ACTIVE    = vga_pkg::H_ACTIVE,
    parameter int H_FRONT_LEN = vga_pkg::H_FRONT_LEN,
    parameter int V_SYNC_LEN  = vga_pkg::V_SYNC_LEN,
    parameter int V_BACK_LEN  = vga_pkg::V_BACK_LEN,
    parameter int V_ACTIVE    = vga_pkg::V_ACTIVE,
    parameter int V_FRONT_LEN = vga_pkg::V_FRONT_LEN
) (
    input  logic       PCLK,
    input  logic       rst,
    output vga_flags_t raw_flags
);

    localparam int H_TOTAL     = H_SYNC_LEN + H_BACK_LEN + H_ACTIVE + H_FRONT_LEN;
    localparam int H_ACT_START = H_SYNC_LEN + H_BACK_LEN;
    localparam int H_ACT_END   = H_ACT_START + H_ACTIVE;

    localparam int V_TOTAL     = V_SYNC_LEN + V_BACK_LEN + V_ACTIVE + V_FRONT_LEN;
    localparam int V_ACT_START = V_SYNC_LEN + V_BACK_LEN;
    localparam int V_ACT_END   = V_ACT_START + V_ACTIVE;

    h_count_t h_count;
    v_count_t v_count;
    logic     h_last;
    logic     v_last;

    assign h_last = (h_count == h_count_t'(H_TOTAL - 1));
    assign v_last = (v_count == v_count_t'(V_TOTAL - 1));

    always_ff @(posedge PCLK) begin
        if (rst || h_last) begin
            h_count <= '0;
        end else begin
            h_count <= h_count + 1'b1;
        end
    end

    // Line counter steps on the last clock of each line
    always_ff @(posedge PCLK) begin
        if (rst) begin
            v_count <= '0;
        end else if (h_last) begin
            v_count <= v_last ? '0 : v_count + 1'b1;
        end
    end

    always_comb begin
        raw_flags.hsync  = (h_count >= h_count_t'(H_SYNC_LEN));
        raw_flags.vsync  = (v_count >= v_count_t'(V_SYNC_LEN));
        raw_flags.hblank = (h_count < h_count_t'(H_ACT_START))
                        || (h_count >= h_count_t'(H_ACT_END));
        raw_flags.vblank = (v_count < v_count_t'(V_ACT_START))
                        || (v_count >= v_count_t'(V_ACT_END));
    end

endmodule

//--- src/swatch_pattern.sv
`timescale 1ns/1ps

module swatch_pattern
    import vga_pkg::*;
#(
    parameter int SWATCH_W = vga_pkg::SWATCH_W,
    parameter int SWATCH_H = vga_pkg::SWATCH_H
) (
    input  logic       PCLK,
    input  logic       rst,
    input  logic       pattern_en,
    input  pix_index_t pix_index,
    input  vga_flags_t raw_flags,
    output pix_index_t index_q,
    output vga_flags_t idx_flags
);

    localparam int PX_W = $clog2(SWATCH_W);
    localparam int LN_W = $clog2(SWATCH_H);

    logic [PX_W-1:0] px_cnt;
    logic [3:0]      sw_col;
    logic [LN_W-1:0] ln_cnt;
    logic [3:0]      sw_row;
    logic            vsync_d;

    logic active;
    logic frame_start;
    logic px_last;
    logic ln_last;

    assign active      = ~raw_flags.hblank & ~raw_flags.vblank;
    assign frame_start = vsync_d & ~raw_flags.vsync;
    assign px_last     = (px_cnt == PX_W'(SWATCH_W - 1));
    assign ln_last     = (ln_cnt == LN_W'(SWATCH_H - 1));

    always_ff @(posedge PCLK) begin
        if (rst) begin
            vsync_d <= 1'b0;
            px_cnt  <= '0;
            sw_col  <= '0;
            ln_cnt  <= '0;
            sw_row  <= '0;
        end else begin
            vsync_d <= raw_flags.vsync;
            if (frame_start) begin
                px_cnt <= '0;
                sw_col <= '0;
                ln_cnt <= '0;
                sw_row <= '0;
            end else if (active) begin
                if (px_last) begin
                    px_cnt <= '0;
                    sw_col <= sw_col + 1'b1;
                    // Last swatch of the line ends the line
                    if (sw_col == 4'hF) begin
                        ln_cnt <= ln_last ? '0 : ln_cnt + 1'b1;
                        if (ln_last) begin
                            sw_row <= sw_row + 1'b1;
                        end
                    end
                end else begin
                    px_cnt <= px_cnt + 1'b1;
                end
            end
        end
    end

    // First pipeline stage
    always_ff @(posedge PCLK) begin
        if (rst) begin
            idx_flags <= FLAGS_BLANK;
        end else begin
            idx_flags <= raw_flags;
        end
    end

    always_ff @(posedge PCLK) begin
        index_q <= pattern_en ? {sw_row, sw_col} : pix_index;
    end

endmodule

//--- src/palette_out.sv
`timescale 1ns/1ps

module palette_out
    import vga_pkg::*;
(
    input  logic       PCLK,
    input  logic       rst,
    input  pix_index_t index_q,
    input  vga_flags_t idx_flags,
    output logic       hsync,
    output logic       vsync,
    output logic       hblank,
    output logic       vblank,
    output rgb444_t    rgb
);

    // Classic 16-colour system table
    localparam rgb444_t [0:15] SYS_COLORS = {
        12'h000, 12'h800, 12'h080, 12'h880,
        12'h008, 12'h808, 12'h088, 12'hCCC,
        12'h888, 12'hF00, 12'h0F0, 12'hFF0,
        12'h00F, 12'hF0F, 12'h0FF, 12'hFFF
    };

    localparam logic [0:5][3:0] CUBE_LEVELS = {
        4'h0, 4'h6, 4'h8, 4'hB, 4'hD, 4'hF
    };

    localparam logic [0:23][3:0] GRAY_RAMP = {
        4'h1, 4'h2, 4'h2, 4'h3, 4'h3, 4'h4, 4'h4, 4'h5,
        4'h6, 4'h6, 4'h7, 4'h7, 4'h8, 4'h9, 4'h9, 4'hA,
        4'hA, 4'hB, 4'hC, 4'hC, 4'hD, 4'hD, 4'hE, 4'hE
    };

    pix_index_t cube_off;
    logic [2:0] r_dig;
    logic [2:0] g_dig;
    logic [2:0] b_dig;
    logic [4:0] gray_sel;
    rgb444_t    color;
    vga_flags_t out_flags;

    // Blue is the fastest cube digit
    assign cube_off = index_q - 8'd16;
    assign r_dig    = 3'(cube_off / 8'd36);
    assign g_dig    = 3'((cube_off / 8'd6) % 8'd6);
    assign b_dig    = 3'(cube_off % 8'd6);
    assign gray_sel = 5'(index_q - 8'd232);

    always_comb begin
        if (index_q < 8'd16) begin
            color = SYS_COLORS[index_q[3:0]];
        end else if (index_q < 8'd232) begin
            color = {CUBE_LEVELS[r_dig], CUBE_LEVELS[g_dig], CUBE_LEVELS[b_dig]};
        end else begin
            color = {3{GRAY_RAMP[gray_sel]}};
        end
    end

    always_ff @(posedge PCLK) begin
        if (rst) begin
            out_flags <= FLAGS_BLANK;
            rgb       <= '0;
        end else begin
            out_flags <= idx_flags;
            rgb       <= (idx_flags.hblank || idx_flags.vblank) ? '0 : color;
        end
    end

    assign hsync  = out_flags.hsync;
    assign vsync  = out_flags.vsync;
    assign hblank = out_flags.hblank;
    assign vblank = out_flags.vblank;

endmodule

//--- src/vga_top.sv
`timescale 1ns/1ps

module vga_top
    import vga_pkg::*;
#(
    parameter int H_SYNC_LEN  = vga_pkg::H_SYNC_LEN,
    parameter int H_BACK_LEN  = vga_pkg::H_BACK_LEN,
    parameter int H_ACTIVE    = vga_pkg::H_ACTIVE,
    parameter int H_FRONT_LEN = vga_pkg::H_FRONT_LEN,
    parameter int V_SYNC_LEN  = vga_pkg::V_SYNC_LEN,
    parameter int V_BACK_LEN  = vga_pkg::V_BACK_LEN,
    parameter int V_ACTIVE    = vga_pkg::V_ACTIVE,
    parameter int V_FRONT_LEN = vga_pkg::V_FRONT_LEN,
    parameter int SWATCH_W    = vga_pkg::SWATCH_W,
    parameter int SWATCH_H    = vga_pkg::SWATCH_H
) (
    input  logic       PCLK,
    input  logic       rst,
    input  logic       pattern_en,
    input  pix_index_t pix_index,
    output logic       hsync,
    output logic       vsync,
    output logic       hblank,
    output logic       vblank,
    output rgb444_t    rgb
);

    vga_flags_t raw_flags;
    vga_flags_t idx_flags;
    pix_index_t index_q;

    vga_timing #(
        .H_SYNC_LEN  (H_SYNC_LEN),
        .H_BACK_LEN  (H_BACK_LEN),
        .H_ACTIVE    (H_ACTIVE),
        .H_FRONT_LEN (H_FRONT_LEN),
        .V_SYNC_LEN  (V_SYNC_LEN),
        .V_BACK_LEN  (V_BACK_LEN),
        .V_ACTIVE    (V_ACTIVE),
        .V_FRONT_LEN (V_FRONT_LEN)
    ) u_timing (
        .PCLK      (PCLK),
        .rst       (rst),
        .raw_flags (raw_flags)
    );

    swatch_pattern #(
        .SWATCH_W (SWATCH_W),
        .SWATCH_H (SWATCH_H)
    ) u_pattern (
        .PCLK       (PCLK),
        .rst        (rst),
        .pattern_en (pattern_en),
        .pix_index  (pix_index),
        .raw_flags  (raw_flags),
        .index_q    (index_q),
        .idx_flags  (idx_flags)
    );

    palette_out u_palette (
        .PCLK      (PCLK),
        .rst       (rst),
        .index_q   (index_q),
        .idx_flags (idx_flags),
        .hsync     (hsync),
        .vsync     (vsync),
        .hblank    (hblank),
        .vblank    (vblank),
        .rgb       (rgb)
    );

endmodule

//--- tests/vga_asserts.sv
`timescale 1ns/1ps

module vga_asserts
    import vga_pkg::*;
(
    input logic    PCLK,
    input logic    rst,
    input logic    hsync,
    input logic    vsync,
    input logic    hblank,
    input logic    vblank,
    input rgb444_t rgb
);

    // Colour stays dark outside the active area
    rgb_dark_in_blank: assert property (
        @(posedge PCLK) disable iff (rst)
        (hblank || vblank) |-> (rgb == '0)
    ) else $error("rgb is non-zero while hblank or vblank is high");

    // Frame boundaries sit on line starts
    vsync_on_line_start: assert property (
        @(posedge PCLK) disable iff (rst)
        $changed(vsync) |-> $fell(hsync)
    ) else $error("vsync changed away from the first cycle of a line");

    hsync_in_hblank: assert property (
        @(posedge PCLK) disable iff (rst)
        $fell(hsync) |-> hblank
    ) else $error("hsync fell during the active span");

endmodule

bind vga_top vga_asserts u_asserts (
    .PCLK   (PCLK),
    .rst    (rst),
    .hsync  (hsync),
    .vsync  (vsync),
    .hblank (hblank),
    .vblank (vblank),
    .rgb    (rgb)
);

//--- tests/tb_vga.sv
`timescale 1ns/1ps

module tb_vga
    import vga_pkg::*;
();

    localparam int LINE_CLKS  = H_SYNC_LEN + H_BACK_LEN + H_ACTIVE + H_FRONT_LEN;
    localparam int FRAME_LINES = V_SYNC_LEN + V_BACK_LEN + V_ACTIVE + V_FRONT_LEN;
    localparam int WAIT_LIMIT = LINE_CLKS * (FRAME_LINES + 2);

    localparam int SEL_HSYNC  = 0;
    localparam int SEL_VSYNC  = 1;
    localparam int SEL_HBLANK = 2;
    localparam int SEL_VBLANK = 3;

    logic       PCLK;
    logic       rst;
    logic       pattern_en;
    pix_index_t pix_index;
    logic       hsync;
    logic       vsync;
    logic       hblank;
    logic       vblank;
    rgb444_t    rgb;

    int errors;
    int tests_run;
    int tests_failed;

    logic [7:0] vec_kind [$];
    int         vec_a [$];
    int         vec_b [$];
    rgb444_t    vec_rgb [$];

    // One captured frame of active pixels
    rgb444_t frame_rgb [0:V_ACTIVE-1][0:H_ACTIVE-1];

    always #20 PCLK = ~PCLK;

    vga_top u_dut (
        .PCLK       (PCLK),
        .rst        (rst),
        .pattern_en (pattern_en),
        .pix_index  (pix_index),
        .hsync      (hsync),
        .vsync      (vsync),
        .hblank     (hblank),
        .vblank     (vblank),
        .rgb        (rgb)
    );

    task automatic check_rgb(input rgb444_t got, input rgb444_t exp, input string what);
        if (got !== exp) begin
            errors++;
            $display("error at %0t: %s is %03h, expected %03h", $time, what, got, exp);
        end
    endtask

    task automatic check_count(input h_count_t got, input h_count_t exp, input string what);
        if (got !== exp) begin
            errors++;
            $display("error at %0t: %s is %0d, expected %0d", $time, what, got, exp);
        end
    endtask

    task automatic check_flag(input logic got, input logic exp, input string what);
        if (got !== exp) begin
            errors++;
            $display("error at %0t: %s is %b, expected %b", $time, what, got, exp);
        end
    endtask

    task automatic finish_test(input string name, input int err_before);
        tests_run++;
        if (errors == err_before) begin
            $display("test %s: ok", name);
        end else begin
            tests_failed++;
            $display("test %s: failed with %0d errors", name, errors - err_before);
        end
    endtask

    function automatic logic out_bit(input int sel);
        case (sel)
            SEL_HSYNC:  return hsync;
            SEL_VSYNC:  return vsync;
            SEL_HBLANK: return hblank;
            SEL_VBLANK: return vblank;
            default:    return 1'bx;
        endcase
    endfunction

    task automatic load_vectors();
        int         fd;
        int         n;
        string      line;
        logic [7:0] kind;
        int         a;
        int         b;
        rgb444_t    exp;
        fd = $fopen("tests/vga_tests.txt", "r");
        if (fd == 0) begin
            errors++;
            $display("could not open the vector file tests/vga_tests.txt");
            return;
        end
        while (!$feof(fd)) begin
            line = "";
            n = $fgets(line, fd);
            if (n > 1 && line.getc(0) != "#") begin
                n = $sscanf(line, "%s %d %d %h", kind, a, b, exp);
                if (n == 4 && (kind == "P" || kind == "S")) begin
                    vec_kind.push_back(kind);
                    vec_a.push_back(a);
                    vec_b.push_back(b);
                    vec_rgb.push_back(exp);
                end else begin
                    errors++;
                    $display("could not read vector line: %s", line);
                end
            end
        end
        $fclose(fd);
        if (vec_kind.size() == 0) begin
            errors++;
            $display("the vector file holds no vectors");
        end
    endtask

    // Samples at falling edges until the output moves to level
    task automatic wait_edge(input int sel, input logic level, input string what, output bit ok);
        logic prev;
        int   n;
        prev = out_bit(sel);
        ok   = 1'b0;
        n    = 0;
        while (!ok && n < WAIT_LIMIT) begin
            @(negedge PCLK);
            n++;
            ok   = (out_bit(sel) == level) && (prev != level);
            prev = out_bit(sel);
        end
        if (!ok) begin
            errors++;
            $display("timeout: no %s within %0d clocks", what, WAIT_LIMIT);
        end
    endtask

    task automatic wait_active_line(output bit ok);
        logic prev;
        int   n;
        prev = hsync;
        ok   = 1'b0;
        n    = 0;
        while (!ok && n < WAIT_LIMIT) begin
            @(negedge PCLK);
            n++;
            ok   = prev && !hsync && !vblank;
            prev = hsync;
        end
        if (!ok) begin
            errors++;
            $display("timeout: no active line started within %0d clocks", WAIT_LIMIT);
        end
    endtask

    task automatic reset_test();
        int err0;
        int n;
        bit risen;
        err0  = errors;
        n     = 0;
        risen = 1'b0;
        while (!risen && n <= LINE_CLKS) begin
            @(negedge PCLK);
            if (hsync) begin
                risen = 1'b1;
            end else begin
                n++;
                check_flag(hblank, 1'b1, "hblank after reset");
                check_flag(vblank, 1'b1, "vblank after reset");
                check_rgb(rgb, '0, "rgb after reset");
            end
        end
        if (!risen) begin
            errors++;
            $display("timeout: hsync never rose after reset");
        end
        // Reset values still fill both pipeline stages
        check_count(h_count_t'(n), h_count_t'(H_SYNC_LEN + 2), "hsync low after release");
        finish_test("reset", err0);
    endtask

    task automatic line_timing_test();
        int   err0;
        int   n;
        int   hs_len;
        int   hb_start;
        int   hb_len;
        int   line_len;
        logic hs_prev;
        logic hb_prev;
        bit   ok;
        err0     = errors;
        hs_len   = -1;
        hb_start = -1;
        hb_len   = -1;
        line_len = -1;
        wait_active_line(ok);
        n       = 0;
        hs_prev = hsync;
        hb_prev = hblank;
        while (line_len < 0 && n <= LINE_CLKS + 16) begin
            @(negedge PCLK);
            n++;
            if (hsync && !hs_prev && hs_len < 0) begin
                hs_len = n;
            end
            if (!hblank && hb_prev && hb_start < 0) begin
                hb_start = n;
            end
            if (hblank && !hb_prev && hb_start >= 0 && hb_len < 0) begin
                hb_len = n - hb_start;
            end
            if (!hsync && hs_prev) begin
                line_len = n;
            end
            hs_prev = hsync;
            hb_prev = hblank;
        end
        if (line_len < 0) begin
            errors++;
            $display("timeout: no second hsync fall within %0d clocks", LINE_CLKS + 16);
        end
        check_count(h_count_t'(hs_len), h_count_t'(H_SYNC_LEN), "hsync low length");
        check_count(h_count_t'(hb_start), h_count_t'(H_SYNC_LEN + H_BACK_LEN), "hblank fall");
        check_count(h_count_t'(hb_len), h_count_t'(H_ACTIVE), "active span");
        check_count(h_count_t'(line_len), h_count_t'(LINE_CLKS), "line length");
        finish_test("line timing", err0);
    endtask

    task automatic frame_and_blank_test();
        int   err0;
        int   n;
        int   lines;
        int   act_lines;
        int   vs_len;
        int   frame_len;
        logic hs_prev;
        logic vs_prev;
        logic hb_prev;
        bit   ok;
        err0 = errors;
        // Non-zero index, so blanking has something to hide
        @(posedge PCLK);
        pix_index <= 8'd15;
        wait_edge(SEL_VSYNC, 1'b0, "vsync fall", ok);
        lines     = 1;
        act_lines = 0;
        vs_len    = -1;
        frame_len = -1;
        n         = 0;
        hs_prev   = hsync;
        vs_prev   = vsync;
        hb_prev   = hblank;
        while (frame_len < 0 && n <= WAIT_LIMIT) begin
            @(negedge PCLK);
            n++;
            if (!hsync && hs_prev) begin
                lines++;
            end
            if (vsync && !vs_prev) begin
                vs_len = lines - 1;
            end
            if (!hblank && hb_prev && !vblank) begin
                act_lines++;
            end
            if (!vsync && vs_prev) begin
                frame_len = lines - 1;
            end
            if (hblank || vblank) begin
                check_rgb(rgb, '0, "blanked rgb");
            end
            hs_prev = hsync;
            vs_prev = vsync;
            hb_prev = hblank;
        end
        if (frame_len < 0) begin
            errors++;
            $display("timeout: no second vsync fall within %0d clocks", WAIT_LIMIT);
        end
        finish_test("blanking", err0);
        err0 = errors;
        check_count(h_count_t'(frame_len), h_count_t'(FRAME_LINES), "lines per frame");
        check_count(h_count_t'(vs_len), h_count_t'(V_SYNC_LEN), "vsync low lines");
        check_count(h_count_t'(act_lines), h_count_t'(V_ACTIVE), "active lines");
        finish_test("frame timing", err0);
    endtask

    task automatic palette_test(input int i);
        int err0;
        bit ok;
        err0 = errors;
        wait_active_line(ok);
        @(posedge PCLK);
        pix_index <= pix_index_t'(vec_a[i]);
        wait_edge(SEL_HBLANK, 1'b0, "hblank fall", ok);
        repeat (H_ACTIVE / 2) @(negedge PCLK);
        check_flag(hblank, 1'b0, "hblank mid-line");
        check_rgb(rgb, vec_rgb[i], $sformatf("rgb for index %0d", vec_a[i]));
        finish_test($sformatf("palette index %0d", vec_a[i]), err0);
    endtask

    task automatic pattern_test();
        int   err0;
        int   n;
        int   x;
        int   y;
        logic hb_prev;
        logic vs_prev;
        bit   done;
        bit   ok;
        err0 = errors;
        @(posedge PCLK);
        pattern_en <= 1'b1;
        wait_edge(SEL_VSYNC, 1'b0, "vsync fall", ok);
        x       = 0;
        y       = -1;
        n       = 0;
        done    = 1'b0;
        hb_prev = hblank;
        vs_prev = vsync;
        while (!done && n <= WAIT_LIMIT) begin
            @(negedge PCLK);
            n++;
            if (!vblank && !hblank) begin
                if (hb_prev) begin
                    y++;
                    x = 0;
                end
                if (y >= 0 && y < V_ACTIVE && x < H_ACTIVE) begin
                    frame_rgb[y][x] = rgb;
                end
                x++;
            end
            done    = !vsync && vs_prev;
            hb_prev = hblank;
            vs_prev = vsync;
        end
        if (!done) begin
            errors++;
            $display("timeout: pattern frame did not end within %0d clocks", WAIT_LIMIT);
        end
        check_count(h_count_t'(y + 1), h_count_t'(V_ACTIVE), "captured lines");
        finish_test("pattern capture", err0);
        foreach (vec_kind[i]) begin
            if (vec_kind[i] == "S") begin
                err0 = errors;
                check_rgb(frame_rgb[vec_b[i]][vec_a[i]], vec_rgb[i],
                          $sformatf("swatch rgb at %0d,%0d", vec_a[i], vec_b[i]));
                finish_test($sformatf("pattern %0d,%0d", vec_a[i], vec_b[i]), err0);
            end
        end
    endtask

    initial begin
        PCLK         = 1'b0;
        rst          = 1'b1;
        pattern_en   = 1'b0;
        pix_index    = 8'hFF;
        errors       = 0;
        tests_run    = 0;
        tests_failed = 0;

        load_vectors();

        repeat (4) @(posedge PCLK);
        rst <= 1'b0;
        reset_test();
        line_timing_test();
        frame_and_blank_test();

        foreach (vec_kind[i]) begin
            if (vec_kind[i] == "P") begin
                palette_test(i);
            end
        end

        pattern_test();

        $display("%0d tests run, %0d failed, %0d errors", tests_run, tests_failed, errors);
        if (errors == 0) begin
            $display("ALL TESTS PASSED");
        end else begin
            $display("SOME TESTS FAILED");
        end
        $finish;
    end

endmodule

//--- tests/vga_tests.txt
# kind a b rgb. P: a = palette index, b unused, rgb = expected RGB444 in hex
# S: a = x, b = y of an active pixel with the pattern on, rgb = expected RGB444 in hex
P 0 0 000
P 1 0 800
P 7 0 CCC
P 8 0 888
P 9 0 F00
P 15 0 FFF
P 16 0 000
P 17 0 006
P 21 0 00F
P 22 0 060
P 51 0 0FF
P 52 0 600
P 100 0 880
P 123 0 8FF
P 160 0 D00
P 196 0 F00
P 231 0 FFF
P 232 0 111
P 233 0 222
P 240 0 666
P 244 0 888
P 255 0 EEE
S 0 0 000
S 39 0 000
S 39 29 000
S 40 0 800
S 639 0 FFF
S 600 29 FFF
S 0 30 000
S 40 30 006
S 79 59 006
S 639 30 08B
S 120 60 0B6
S 440 90 666
S 200 150 6FB
S 320 240 B80
S 280 330 DBF
S 0 450 666
S 0 479 666
S 599 479 EEE
S 600 450 EEE
S 639 479 EEE

//--- verilog.f
src/vga_pkg.sv
src/vga_timing.sv
src/swatch_pattern.sv
src/palette_out.sv
src/vga_top.sv
tests/vga_asserts.sv
tests/tb_vga.sv

//--- run.sh
#!/bin/sh
# Build and run the VGA testbench with Verilator

cd "$(dirname "$0")" || exit 1

LOG=sim.log

verilator --binary --timing --assert -Wno-fatal --top-module tb_vga -f verilog.f
if [ $? -ne 0 ]; then
    echo "Verilator build failed"
    exit 1
fi

./obj_dir/Vtb_vga > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
    echo "simulation exited with status $status"
    exit 1
fi

if grep -q "SOME TESTS FAILED" "$LOG"; then
    exit 1
fi
exit 0
